// File: bios_loader.f
+incdir+include
hw/bios_pkg.sv
hw/bios_ifs.sv
hw/bios_byte_packer.sv
hw/bios_block_buffer.sv
hw/bios_streamer.sv
hw/bios_loader_top.sv
testbench/bios_loader_chk.sv
testbench/tb_bios_loader.sv

// File: build.sh
#!/bin/sh
# compile the boot-ROM loader testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f bios_loader.f \
	--top-module tb_bios_loader \
	-Mdir obj_dir -o sim_bios_loader
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/sim_bios_loader > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi

// File: include/tb_lfsr.svh
// 32-bit Fibonacci LFSR, included into the testbench module for random bytes and gaps
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// taps 32, 22, 2, 1 give a maximal-length sequence
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic fb;
	fb = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], fb};
endfunction

// takes nbits fresh bits, one step per bit, and advances the state
function automatic logic [31:0] random_bits(inout logic [31:0] state, input int nbits);
	logic [31:0] value;
	value = '0;
	for (int i = 0; i < nbits; i++) begin
		state = lfsr_next(state);
		value = {value[30:0], state[0]};
	end
	return value;
endfunction

`endif

// File: testbench/tb_bios_loader.sv
// testbench for the boot-ROM loader, random downloads checked against a word model
`timescale 1ns/1ps
`default_nettype none

module tb_bios_loader;

	localparam int CLK_PERIOD = 40;
	localparam int BUF_IDX_W = 6;
	localparam int BIOS_ADDR_W = 14;
	localparam int ADDR_W = bios_pkg::IOCTL_ADDR_W;
	localparam int BLOCKS = 4;
	localparam int DOWNLOADS = 2;
	localparam int BLOCK_WORDS = 32;
	localparam int BUF_WORDS = 2 * BLOCK_WORDS;
	localparam int MAX_GAP = 3;
	localparam logic [31:0] SEED = 32'hb789;
	localparam int TOTAL_BYTES = DOWNLOADS * BLOCKS * BLOCK_WORDS * 2;
	localparam int TIMEOUT_CYCLES = TOTAL_BYTES * (MAX_GAP + 2)
		+ DOWNLOADS * BLOCKS * (BLOCK_WORDS + 16) + 200;

	logic                   clk_cpu;
	logic                   rst_i;
	logic                   ioctl_downl_i;
	logic                   ioctl_wr_i;
	logic [ADDR_W-1:0]      ioctl_addr_i;
	bios_pkg::byte_t        ioctl_dout_i;
	logic                   bios_req_i;
	logic                   reset_btn_i;
	logic [BIOS_ADDR_W-1:0] bios_addr_o;
	bios_pkg::word_t        bios_din_o;
	logic                   bios_wr_o;
	logic                   cpu_reset_o;

	logic [31:0]     lfsr_state;
	bios_pkg::word_t model_buf [BUF_WORDS];
	bios_pkg::byte_t model_low;
	int              model_addr;

	`include "tb_lfsr.svh"

	bios_loader_top #(
		.BUF_IDX_W     (BUF_IDX_W),
		.BIOS_ADDR_W   (BIOS_ADDR_W)
	) uut (
		.clk_cpu       (clk_cpu),
		.rst_i         (rst_i),
		.ioctl_downl_i (ioctl_downl_i),
		.ioctl_wr_i    (ioctl_wr_i),
		.ioctl_addr_i  (ioctl_addr_i),
		.ioctl_dout_i  (ioctl_dout_i),
		.bios_req_i    (bios_req_i),
		.reset_btn_i   (reset_btn_i),
		.bios_addr_o   (bios_addr_o),
		.bios_din_o    (bios_din_o),
		.bios_wr_o     (bios_wr_o),
		.cpu_reset_o   (cpu_reset_o)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #(CLK_PERIOD / 2) clk_cpu = ~clk_cpu;
	end

	// worst case is every byte followed by the longest gap
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the test did not complete", TIMEOUT_CYCLES);
		$display("TESTS FAILED");
		$fatal(1, "watchdog timeout");
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			$display("error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// one strobe cycle, then a random gap
	task automatic send_byte(input int byte_addr);
		bios_pkg::byte_t value;
		int gap;
		value = bios_pkg::byte_t'(random_bits(lfsr_state, 8));
		gap = int'(random_bits(lfsr_state, 2));
		@(negedge clk_cpu);
		ioctl_wr_i = 1'b1;
		ioctl_addr_i = ADDR_W'(byte_addr);
		ioctl_dout_i = value;
		// low byte first, odd byte completes the word
		if (byte_addr % 2 == 1) begin
			model_buf[(byte_addr / 2) % BUF_WORDS] = {value, model_low};
		end else begin
			model_low = value;
		end
		@(negedge clk_cpu);
		ioctl_wr_i = 1'b0;
		repeat (gap) @(negedge clk_cpu);
	endtask

	task automatic wait_block_ready();
		int cycles;
		cycles = 0;
		while (bios_wr_o !== 1'b1 && cycles < 8) begin
			@(negedge clk_cpu);
			cycles++;
		end
		assert (bios_wr_o === 1'b1) else begin
			$display("block-ready did not rise within 8 cycles after the last byte of a block");
			$display("TESTS FAILED");
			$fatal(1, "block-ready timeout");
		end
	endtask

	task automatic fill_block(input int blk);
		int base;
		base = blk * BLOCK_WORDS * 2;
		for (int i = 0; i < BLOCK_WORDS * 2; i++) begin
			send_byte(base + i);
			// 62nd byte, block not yet complete
			if (i == BLOCK_WORDS * 2 - 3) begin
				repeat (2) @(negedge clk_cpu);
				check_value("bios_wr_o", 32'(bios_wr_o), 32'd0);
			end
		end
		wait_block_ready();
	endtask

	// data lags the address counter by one word
	task automatic read_block();
		@(negedge clk_cpu);
		bios_req_i = 1'b1;
		for (int i = 0; i < BLOCK_WORDS; i++) begin
			@(negedge clk_cpu);
			check_value("bios_addr_o", 32'(bios_addr_o), 32'(model_addr + 1));
			check_value("bios_din_o", 32'(bios_din_o), 32'(model_buf[model_addr % BUF_WORDS]));
			model_addr++;
		end
		bios_req_i = 1'b0;
		@(negedge clk_cpu);
		check_value("bios_wr_o", 32'(bios_wr_o), 32'd0);
	endtask

	task automatic run_download();
		@(negedge clk_cpu);
		ioctl_downl_i = 1'b1;
		@(negedge clk_cpu);
		check_value("bios_addr_o", 32'(bios_addr_o), 32'd0);
		model_addr = 0;
		for (int b = 0; b < BLOCKS; b++) begin
			fill_block(b);
			check_value("cpu_reset_o", 32'(cpu_reset_o), 32'd1);
			read_block();
		end
		// state moves on the first edge, reset register on the second
		ioctl_downl_i = 1'b0;
		@(negedge clk_cpu);
		check_value("cpu_reset_o", 32'(cpu_reset_o), 32'd1);
		@(negedge clk_cpu);
		check_value("cpu_reset_o", 32'(cpu_reset_o), 32'd0);
	endtask

	task automatic press_reset_button();
		@(negedge clk_cpu);
		reset_btn_i = 1'b1;
		@(negedge clk_cpu);
		check_value("cpu_reset_o", 32'(cpu_reset_o), 32'd1);
		reset_btn_i = 1'b0;
		@(negedge clk_cpu);
		check_value("cpu_reset_o", 32'(cpu_reset_o), 32'd0);
	endtask

	initial begin
		rst_i = 1'b1;
		ioctl_downl_i = 1'b0;
		ioctl_wr_i = 1'b0;
		ioctl_addr_i = '0;
		ioctl_dout_i = '0;
		bios_req_i = 1'b0;
		reset_btn_i = 1'b0;
		lfsr_state = SEED;
		model_low = '0;
		model_addr = 0;
		repeat (2) @(posedge clk_cpu);
		@(negedge clk_cpu);
		rst_i = 1'b0;
		check_value("bios_wr_o", 32'(bios_wr_o), 32'd0);
		check_value("bios_addr_o", 32'(bios_addr_o), 32'd0);
		check_value("cpu_reset_o", 32'(cpu_reset_o), 32'd1);
		for (int d = 0; d < DOWNLOADS; d++) begin
			run_download();
			press_reset_button();
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/bios_loader_chk.sv
// concurrent port checks for the boot-ROM loader, attached to bios_loader_top with bind
`timescale 1ns/1ps
`default_nettype none

module bios_loader_chk #(
	parameter int BIOS_ADDR_W = 14
) (
	input  wire logic                   clk_cpu,
	input  wire logic                   rst_i,
	input  wire logic                   ioctl_downl_i,
	input  wire logic                   ioctl_wr_i,
	input  wire logic                   ioctl_addr_lsb_i,
	input  wire logic                   bios_req_i,
	input  wire logic                   reset_btn_i,
	input  wire logic [BIOS_ADDR_W-1:0] bios_addr_i,
	input  wire logic                   bios_wr_i,
	input  wire logic                   cpu_reset_i
);

	logic downl_q;
	logic odd_strobe;
	logic dl_start;

	// a byte that completes a word
	assign odd_strobe = ioctl_downl_i & ioctl_wr_i & ioctl_addr_lsb_i;

	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			downl_q <= 1'b0;
		end else begin
			downl_q <= ioctl_downl_i;
		end
	end

	assign dl_start = ioctl_downl_i & ~downl_q;

	// strobe, word write, then the flag
	ready_after_odd_byte: assert property (@(posedge clk_cpu) disable iff (rst_i)
		$rose(bios_wr_i) |-> $past(odd_strobe, 2))
		else $error("block-ready rose without an odd-address byte strobe");

	addr_moves_on_request: assert property (@(posedge clk_cpu) disable iff (rst_i)
		(bios_addr_i != $past(bios_addr_i)) |-> ($past(bios_req_i) || $past(dl_start)))
		else $error("boot-ROM address changed without a request or download start");

	reset_follows_button: assert property (@(posedge clk_cpu)
		$past(reset_btn_i) |-> cpu_reset_i)
		else $error("CPU reset low one cycle after the reset button was high");

endmodule

bind bios_loader_top bios_loader_chk #(
	.BIOS_ADDR_W      (BIOS_ADDR_W)
) chk (
	.clk_cpu          (clk_cpu),
	.rst_i            (rst_i),
	.ioctl_downl_i    (ioctl_downl_i),
	.ioctl_wr_i       (ioctl_wr_i),
	.ioctl_addr_lsb_i (ioctl_addr_i[0]),
	.bios_req_i       (bios_req_i),
	.reset_btn_i      (reset_btn_i),
	.bios_addr_i      (bios_addr_o),
	.bios_wr_i        (bios_wr_o),
	.cpu_reset_i      (cpu_reset_o)
);

`default_nettype wire

// File: hw/bios_loader_top.sv
// top level of the boot-ROM loader; connects packer, buffer and streamer on clk_cpu
`timescale 1ns/1ps
`default_nettype none

module bios_loader_top #(
	parameter int BUF_IDX_W   = 6,
	parameter int BIOS_ADDR_W = 14
) (
	input  wire logic                              clk_cpu,
	input  wire logic                              rst_i,
	// I/O controller download port
	input  wire logic                              ioctl_downl_i,
	input  wire logic                              ioctl_wr_i,
	input  wire logic [bios_pkg::IOCTL_ADDR_W-1:0] ioctl_addr_i,
	input  wire bios_pkg::byte_t                   ioctl_dout_i,
	// CPU boot-ROM port
	input  wire logic                              bios_req_i,
	input  wire logic                              reset_btn_i,
	output logic [BIOS_ADDR_W-1:0]                 bios_addr_o,
	output bios_pkg::word_t                        bios_din_o,
	output logic                                   bios_wr_o,
	output logic                                   cpu_reset_o
);

	logic loaded;

	word_wr_if #(.BUF_IDX_W(BUF_IDX_W)) wr_bus ();
	word_rd_if #(.BUF_IDX_W(BUF_IDX_W)) rd_bus ();

	bios_byte_packer #(
		.BUF_IDX_W     (BUF_IDX_W)
	) u_packer (
		.clk_cpu       (clk_cpu),
		.rst_i         (rst_i),
		.ioctl_downl_i (ioctl_downl_i),
		.ioctl_wr_i    (ioctl_wr_i),
		.ioctl_addr_i  (ioctl_addr_i),
		.ioctl_dout_i  (ioctl_dout_i),
		.loaded_o      (loaded),
		.wr            (wr_bus.packer)
	);

	bios_block_buffer #(
		.BUF_IDX_W (BUF_IDX_W)
	) u_buffer (
		.clk_cpu   (clk_cpu),
		.rst_i     (rst_i),
		.wr        (wr_bus.buffer),
		.rd        (rd_bus.buffer)
	);

	bios_streamer #(
		.BUF_IDX_W   (BUF_IDX_W),
		.BIOS_ADDR_W (BIOS_ADDR_W)
	) u_streamer (
		.clk_cpu     (clk_cpu),
		.rst_i       (rst_i),
		.bios_req_i  (bios_req_i),
		.reset_btn_i (reset_btn_i),
		.loaded_i    (loaded),
		.bios_addr_o (bios_addr_o),
		.bios_din_o  (bios_din_o),
		.bios_wr_o   (bios_wr_o),
		.cpu_reset_o (cpu_reset_o),
		.wr          (wr_bus.streamer),
		.rd          (rd_bus.streamer)
	);

endmodule

`default_nettype wire

// File: hw/bios_streamer.sv
// CPU side of the loader: boot-ROM address counter, request edge and CPU reset register
`timescale 1ns/1ps
`default_nettype none

module bios_streamer #(
	parameter int BUF_IDX_W   = 6,
	parameter int BIOS_ADDR_W = 14
) (
	input  wire logic              clk_cpu,
	input  wire logic              rst_i,
	input  wire logic              bios_req_i,
	input  wire logic              reset_btn_i,
	input  wire logic              loaded_i,
	output logic [BIOS_ADDR_W-1:0] bios_addr_o,
	output bios_pkg::word_t        bios_din_o,
	output logic                   bios_wr_o,
	output logic                   cpu_reset_o,
	word_wr_if.streamer            wr,
	word_rd_if.streamer            rd
);

	logic                   req_q;
	logic [BIOS_ADDR_W-1:0] addr_q;
	logic                   cpu_reset_q;

	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			req_q <= 1'b0;
		end else begin
			req_q <= bios_req_i;
		end
	end

	// CPU drops the request once it has taken the block
	assign rd.blk_release = req_q & ~bios_req_i;

	// one word per clock while the request is held
	assign rd.rd = bios_req_i & wr.active;
	assign rd.index = addr_q[BUF_IDX_W-1:0];

	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			addr_q <= '0;
		end else if (wr.start) begin
			addr_q <= '0;
		end else if (rd.rd) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	assign bios_addr_o = addr_q;

	// word at the previous address, one clock behind the counter
	assign bios_din_o = rd.data;
	assign bios_wr_o = rd.ready;

	// CPU stays in reset until the image is in place
	always_ff @(posedge clk_cpu) begin
		cpu_reset_q <= rst_i | reset_btn_i | ~loaded_i;
	end

	assign cpu_reset_o = cpu_reset_q;

endmodule

`default_nettype wire

// File: hw/bios_block_buffer.sv
// two-block word buffer between the download stream and the CPU, with the block-ready flag
`timescale 1ns/1ps
`default_nettype none

module bios_block_buffer #(
	parameter int BUF_IDX_W = 6
) (
	input  wire logic  clk_cpu,
	input  wire logic  rst_i,
	word_wr_if.buffer  wr,
	word_rd_if.buffer  rd
);

	localparam int DEPTH = 2 ** BUF_IDX_W;

	bios_pkg::word_t mem [DEPTH];
	bios_pkg::word_t rd_data_q;
	logic            ready_q;
	logic            block_end;

	// last word of either half, the top index bit selects the half
	assign block_end = &wr.index[BUF_IDX_W-2:0];

	always_ff @(posedge clk_cpu) begin
		if (wr.wr) begin
			mem[wr.index] <= wr.data;
		end
	end

	// registered read port
	always_ff @(posedge clk_cpu) begin
		if (rd.rd) begin
			rd_data_q <= mem[rd.index];
		end
	end

	assign rd.data = rd_data_q;

	// block-ready flag
	// clears win over a block end in the same cycle
	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			ready_q <= 1'b0;
		end else if (wr.start) begin
			ready_q <= 1'b0;
		end else if (rd.blk_release) begin
			ready_q <= 1'b0;
		end else if (wr.wr && block_end) begin
			ready_q <= 1'b1;
		end
	end

	assign rd.ready = ready_q;

endmodule

`default_nettype wire

// File: hw/bios_byte_packer.sv
// download input side: pairs I/O controller bytes into words and tracks the download progress
`timescale 1ns/1ps
`default_nettype none

module bios_byte_packer #(
	parameter int BUF_IDX_W = 6
) (
	input  wire logic                              clk_cpu,
	input  wire logic                              rst_i,
	input  wire logic                              ioctl_downl_i,
	input  wire logic                              ioctl_wr_i,
	input  wire logic [bios_pkg::IOCTL_ADDR_W-1:0] ioctl_addr_i,
	input  wire bios_pkg::byte_t                   ioctl_dout_i,
	output logic                                   loaded_o,
	word_wr_if.packer                              wr
);

	logic                  downl_q;
	bios_pkg::byte_t       low_byte_q;
	bios_pkg::load_state_e state_q;
	bios_pkg::load_state_e state_d;
	logic                  byte_strobe;

	// bytes only count while the controller holds the download level
	assign byte_strobe = ioctl_downl_i & ioctl_wr_i;

	// delayed download level
	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			downl_q <= 1'b0;
		end else begin
			downl_q <= ioctl_downl_i;
		end
	end

	// rising edge of the level marks a new download
	assign wr.start = ioctl_downl_i & ~downl_q;
	assign wr.active = downl_q;

	// even address holds the low byte until its partner arrives
	always_ff @(posedge clk_cpu) begin
		if (byte_strobe && !ioctl_addr_i[0]) begin
			low_byte_q <= ioctl_dout_i;
		end
	end

	// odd address completes the word, written one clock later
	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			wr.wr <= 1'b0;
		end else begin
			wr.wr <= byte_strobe & ioctl_addr_i[0];
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (byte_strobe && ioctl_addr_i[0]) begin
			wr.index <= ioctl_addr_i[BUF_IDX_W:1];
			wr.data <= {ioctl_dout_i, low_byte_q};
		end
	end

	// load state, a new download takes the CPU back into reset
	always_comb begin
		state_d = state_q;
		case (state_q)
			bios_pkg::LOAD_IDLE: begin
				if (ioctl_downl_i) state_d = bios_pkg::LOAD_ACTIVE;
			end
			bios_pkg::LOAD_ACTIVE: begin
				if (!ioctl_downl_i) state_d = bios_pkg::LOAD_DONE;
			end
			bios_pkg::LOAD_DONE: begin
				if (ioctl_downl_i) state_d = bios_pkg::LOAD_ACTIVE;
			end
			default: state_d = bios_pkg::LOAD_IDLE;
		endcase
	end

	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			state_q <= bios_pkg::LOAD_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign loaded_o = (state_q == bios_pkg::LOAD_DONE);

endmodule

`default_nettype wire

// File: hw/bios_ifs.sv
// internal buffer write and read interfaces of the boot-ROM loader, with per-module modports
`timescale 1ns/1ps
`default_nettype none

// packed words from the byte packer into the block buffer
interface word_wr_if #(
	parameter int BUF_IDX_W = 6
) ();
	logic                 wr;
	logic [BUF_IDX_W-1:0] index;
	bios_pkg::word_t      data;
	// first cycle of a download
	logic                 start;
	// registered download level
	logic                 active;

	modport packer (output wr, index, data, start, active);
	modport buffer (input wr, index, data, start);
	modport streamer (input start, active);
endinterface

// word reads from the block buffer towards the CPU side
interface word_rd_if #(
	parameter int BUF_IDX_W = 6
) ();
	logic                 rd;
	logic [BUF_IDX_W-1:0] index;
	// valid one clock after rd
	bios_pkg::word_t      data;
	// one-cycle pulse on the falling request
	logic                 blk_release;
	// block-ready level
	logic                 ready;

	modport buffer (input rd, index, blk_release, output data, ready);
	modport streamer (output rd, index, blk_release, input data, ready);
endinterface

`default_nettype wire

// File: hw/bios_pkg.sv
// shared widths, data types and loader state for the boot-ROM download path, referenced by scope
`default_nettype none

package bios_pkg;

	// byte address width of the I/O controller download port
	localparam int IOCTL_ADDR_W = 25;

	// one download byte as delivered by the I/O controller
	typedef logic [7:0] byte_t;

	// one boot-ROM word, low byte first on the download stream
	typedef logic [15:0] word_t;

	// loader progress as seen from the download level
	typedef enum logic [1:0] {
		// nothing seen since reset
		LOAD_IDLE,
		// download level is high
		LOAD_ACTIVE,
		// download level has dropped, CPU may run
		LOAD_DONE
	} load_state_e;

endpackage

`default_nettype wire
